//--- rtl/rvIsaPkg.sv
package rvIsaPkg;

  typedef enum logic [6:0] {
    opReg   = 7'b0110011,
    opImm   = 7'b0010011,
    opLoad  = 7'b0000011,
    opStore = 7'b0100011
  } rvOpcode_t;

  // One instruction word seen through the R, I and S field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } rType;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } iType;
    struct packed {
      logic [6:0] immHigh;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLow;
      logic [6:0] opcode;
    } sType;
  } rvInstr_t;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSll,
    aluSrl
  } aluOp_t;

  localparam logic [2:0] funct3AddSub = 3'b000;
  localparam logic [2:0] funct3Sll    = 3'b001;
  localparam logic [2:0] funct3Slt    = 3'b010;
  localparam logic [2:0] funct3Xor    = 3'b100;
  localparam logic [2:0] funct3Srl    = 3'b101;
  localparam logic [2:0] funct3Or     = 3'b110;
  localparam logic [2:0] funct3And    = 3'b111;
  // lw and sw share this width code
  localparam logic [2:0] funct3Word   = 3'b010;

  localparam logic [6:0] funct7Base   = 7'b0000000;
  localparam logic [6:0] funct7Sub    = 7'b0100000;

endpackage

//--- rtl/pipeCtrlPkg.sv
package pipeCtrlPkg;

  // Source of an ALU operand in execute
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSel_t;

  // x0 is never written, never forwarded and always reads zero
  localparam logic [4:0] zeroReg = 5'd0;

endpackage

//--- rtl/FetchStage.sv
`timescale 1ns/100ps

module FetchStage #(
  parameter int instrMemWords = 64
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic        stall,
  input  logic        imemWrite,
  input  logic [31:0] imemAddress,
  input  logic [31:0] imemData,
  output logic [31:0] idInstruction,
  output logic        idValid
);

  localparam int addrBits = $clog2(instrMemWords);

  logic [31:0] instrMem [instrMemWords];
  logic [31:0] pc;
  logic [31:0] fetchedInstruction;

  // Program load port takes a word index on imemAddress
  always_ff @(posedge clk) begin
    if (imemWrite) begin
      instrMem[imemAddress[addrBits-1:0]] <= imemData;
    end
  end

  assign fetchedInstruction = instrMem[pc[addrBits+1:2]];

  always_ff @(posedge clk) begin
    if (reset || !run) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // ****************************************
  // IF/ID register
  // ****************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      idValid <= 1'b0;
    end else if (!stall) begin
      idValid <= run;
    end
  end

  // Held in place while decode waits on a load
  always_ff @(posedge clk) begin
    if (!stall) begin
      idInstruction <= fetchedInstruction;
    end
  end

endmodule

//--- rtl/DecodeStage.sv
`timescale 1ns/100ps

module DecodeStage
  import rvIsaPkg::*, pipeCtrlPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] idInstruction,
  input  logic        idValid,
  input  logic [4:0]  wbWriteIndex,
  input  logic [31:0] wbWriteData,
  input  logic        wbRegWrite,
  output logic        stall,
  output logic [31:0] exLhsValue,
  output logic [31:0] exRhsValue,
  output logic [4:0]  exLhsIndex,
  output logic [4:0]  exRhsIndex,
  output logic [4:0]  exWriteIndex,
  output logic [31:0] exImmediate,
  output aluOp_t      exAluOp,
  output logic        exAluSrc,
  output logic        exMemRead,
  output logic        exMemWrite,
  output logic        exMemToReg,
  output logic        exRegWrite
);

  rvInstr_t    instr;
  logic [4:0]  lhsIndex;
  logic [4:0]  rhsIndex;
  logic [4:0]  writeIndex;
  logic [31:0] lhsValue;
  logic [31:0] rhsValue;
  logic [31:0] immediate;
  aluOp_t      aluOp;
  logic        aluSrc;
  logic        memRead;
  logic        memWrite;
  logic        memToReg;
  logic        regWrite;
  logic [31:0] regFile [1:31];

  assign instr      = idInstruction;
  assign lhsIndex   = instr.rType.rs1;
  assign rhsIndex   = instr.rType.rs2;
  assign writeIndex = instr.rType.rd;

  // ****************************************
  // Control decode and immediate
  // ****************************************
  always_comb begin
    aluOp     = aluAdd;
    aluSrc    = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    immediate = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
    case (instr.rType.opcode)
      opReg: begin
        regWrite = 1'b1;
        case ({instr.rType.funct7, instr.rType.funct3})
          {funct7Base, funct3AddSub}: aluOp = aluAdd;
          {funct7Sub, funct3AddSub}:  aluOp = aluSub;
          {funct7Base, funct3Sll}:    aluOp = aluSll;
          {funct7Base, funct3Slt}:    aluOp = aluSlt;
          {funct7Base, funct3Xor}:    aluOp = aluXor;
          {funct7Base, funct3Srl}:    aluOp = aluSrl;
          {funct7Base, funct3Or}:     aluOp = aluOr;
          {funct7Base, funct3And}:    aluOp = aluAnd;
          default:                    regWrite = 1'b0;
        endcase
      end
      opImm: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        case (instr.iType.funct3)
          funct3AddSub: aluOp = aluAdd;
          funct3Slt:    aluOp = aluSlt;
          funct3Xor:    aluOp = aluXor;
          funct3Or:     aluOp = aluOr;
          funct3And:    aluOp = aluAnd;
          default:      regWrite = 1'b0;
        endcase
      end
      opLoad: begin
        if (instr.iType.funct3 == funct3Word) begin
          aluSrc   = 1'b1;
          memRead  = 1'b1;
          memToReg = 1'b1;
          regWrite = 1'b1;
        end
      end
      opStore: begin
        immediate = {{20{instr.sType.immHigh[6]}}, instr.sType.immHigh, instr.sType.immLow};
        if (instr.sType.funct3 == funct3Word) begin
          aluSrc   = 1'b1;
          memWrite = 1'b1;
        end
      end
      default: begin
        // Anything outside the subset is a no-op
      end
    endcase
    if (writeIndex == zeroReg) begin
      regWrite = 1'b0;
    end
  end

  // Hold one cycle when a load in execute feeds this instruction
  assign stall = idValid && exMemRead && exRegWrite &&
                 (exWriteIndex == lhsIndex || exWriteIndex == rhsIndex);

  // ****************************************
  // Register file
  // ****************************************
  function automatic logic [31:0] readReg(input logic [4:0] index);
    if (index == zeroReg) begin
      return '0;
    end
    // Same-cycle write shows through
    if (wbRegWrite && wbWriteIndex == index) begin
      return wbWriteData;
    end
    return regFile[index];
  endfunction

  always_comb begin
    lhsValue = readReg(lhsIndex);
    rhsValue = readReg(rhsIndex);
  end

  always_ff @(posedge clk) begin
    if (wbRegWrite && wbWriteIndex != zeroReg) begin
      regFile[wbWriteIndex] <= wbWriteData;
    end
  end

  // ****************************************
  // ID/EX register
  // ****************************************
  always_ff @(posedge clk) begin
    exLhsValue   <= lhsValue;
    exRhsValue   <= rhsValue;
    exLhsIndex   <= lhsIndex;
    exRhsIndex   <= rhsIndex;
    exWriteIndex <= writeIndex;
    exImmediate  <= immediate;
    exAluOp      <= aluOp;
    exAluSrc     <= aluSrc;
  end

  // A stall or an empty slot becomes a bubble
  always_ff @(posedge clk) begin
    if (reset || stall || !idValid) begin
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exRegWrite <= 1'b0;
    end else begin
      exMemRead  <= memRead;
      exMemWrite <= memWrite;
      exMemToReg <= memToReg;
      exRegWrite <= regWrite;
    end
  end

endmodule

//--- rtl/ExecuteStage.sv
`timescale 1ns/100ps

module ExecuteStage
  import rvIsaPkg::*, pipeCtrlPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] exLhsValue,
  input  logic [31:0] exRhsValue,
  input  logic [4:0]  exLhsIndex,
  input  logic [4:0]  exRhsIndex,
  input  logic [4:0]  exWriteIndex,
  input  logic [31:0] exImmediate,
  input  aluOp_t      exAluOp,
  input  logic        exAluSrc,
  input  logic        exMemRead,
  input  logic        exMemWrite,
  input  logic        exMemToReg,
  input  logic        exRegWrite,
  input  logic [4:0]  wbWriteIndex,
  input  logic [31:0] wbWriteData,
  input  logic        wbRegWrite,
  output logic [31:0] memAluResult,
  output logic [31:0] memStoreData,
  output logic [4:0]  memWriteIndex,
  output logic        memMemRead,
  output logic        memMemWrite,
  output logic        memMemToReg,
  output logic        memRegWrite
);

  fwdSel_t     lhsSel;
  fwdSel_t     rhsSel;
  logic [31:0] lhsOperand;
  logic [31:0] rhsRegister;
  logic [31:0] rhsOperand;
  logic [31:0] aluResult;

  // ****************************************
  // Forwarding
  // ****************************************
  // Newest producer wins, so memory is checked before writeback
  function automatic fwdSel_t pickSource(input logic [4:0] index);
    if (index == zeroReg) begin
      return fwdNone;
    end
    if (memRegWrite && memWriteIndex == index) begin
      return fwdMem;
    end
    if (wbRegWrite && wbWriteIndex == index) begin
      return fwdWb;
    end
    return fwdNone;
  endfunction

  function automatic logic [31:0] operandValue(input fwdSel_t sel, input logic [31:0] regValue);
    case (sel)
      fwdMem:  return memAluResult;
      fwdWb:   return wbWriteData;
      default: return regValue;
    endcase
  endfunction

  always_comb begin
    lhsSel      = pickSource(exLhsIndex);
    rhsSel      = pickSource(exRhsIndex);
    lhsOperand  = operandValue(lhsSel, exLhsValue);
    rhsRegister = operandValue(rhsSel, exRhsValue);
    // Store data keeps the forwarded register and skips the immediate
    rhsOperand  = exAluSrc ? exImmediate : rhsRegister;
  end

  // ****************************************
  // ALU
  // ****************************************
  always_comb begin
    case (exAluOp)
      aluSub:  aluResult = lhsOperand - rhsOperand;
      aluAnd:  aluResult = lhsOperand & rhsOperand;
      aluOr:   aluResult = lhsOperand | rhsOperand;
      aluXor:  aluResult = lhsOperand ^ rhsOperand;
      aluSlt:  aluResult = {31'd0, $signed(lhsOperand) < $signed(rhsOperand)};
      aluSll:  aluResult = lhsOperand << rhsOperand[4:0];
      aluSrl:  aluResult = lhsOperand >> rhsOperand[4:0];
      default: aluResult = lhsOperand + rhsOperand;
    endcase
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    memAluResult  <= aluResult;
    memStoreData  <= rhsRegister;
    memWriteIndex <= exWriteIndex;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      memMemRead  <= 1'b0;
      memMemWrite <= 1'b0;
      memMemToReg <= 1'b0;
      memRegWrite <= 1'b0;
    end else begin
      memMemRead  <= exMemRead;
      memMemWrite <= exMemWrite;
      memMemToReg <= exMemToReg;
      memRegWrite <= exRegWrite;
    end
  end

endmodule

//--- rtl/MemoryStage.sv
`timescale 1ns/100ps

module MemoryStage #(
  parameter int dataMemWords = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] memAluResult,
  input  logic [31:0] memStoreData,
  input  logic [4:0]  memWriteIndex,
  input  logic        memMemRead,
  input  logic        memMemWrite,
  input  logic        memMemToReg,
  input  logic        memRegWrite,
  output logic [4:0]  wbWriteIndex,
  output logic [31:0] wbWriteData,
  output logic        wbRegWrite
);

  localparam int addrBits = $clog2(dataMemWords);

  logic [31:0]         dataMem [dataMemWords];
  logic [addrBits-1:0] wordIndex;
  logic [31:0]         loadData;
  logic [31:0]         wbLoadData;
  logic [31:0]         wbAluResult;
  logic                wbMemToReg;

  // Byte address to word index wrapped to the array size
  assign wordIndex = memAluResult[addrBits+1:2];
  assign loadData  = memMemRead ? dataMem[wordIndex] : '0;

  always_ff @(posedge clk) begin
    if (memMemWrite) begin
      dataMem[wordIndex] <= memStoreData;
    end
  end

  // MEM/WB register
  always_ff @(posedge clk) begin
    wbLoadData   <= loadData;
    wbAluResult  <= memAluResult;
    wbWriteIndex <= memWriteIndex;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wbMemToReg <= 1'b0;
      wbRegWrite <= 1'b0;
    end else begin
      wbMemToReg <= memMemToReg;
      wbRegWrite <= memRegWrite;
    end
  end

  // Writeback select
  assign wbWriteData = wbMemToReg ? wbLoadData : wbAluResult;

endmodule

//--- rtl/Cpu.sv
`timescale 1ns/100ps

module Cpu
  import rvIsaPkg::*;
#(
  parameter int instrMemWords = 64,
  parameter int dataMemWords  = 32
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  input  logic        imemWrite,
  input  logic [31:0] imemAddress,
  input  logic [31:0] imemData,
  output logic        wbValid,
  output logic [4:0]  wbIndex,
  output logic [31:0] wbData
);

  logic [31:0] idInstruction;
  logic        idValid;
  logic        stall;

  logic [31:0] exLhsValue;
  logic [31:0] exRhsValue;
  logic [4:0]  exLhsIndex;
  logic [4:0]  exRhsIndex;
  logic [4:0]  exWriteIndex;
  logic [31:0] exImmediate;
  aluOp_t      exAluOp;
  logic        exAluSrc;
  logic        exMemRead;
  logic        exMemWrite;
  logic        exMemToReg;
  logic        exRegWrite;

  logic [31:0] memAluResult;
  logic [31:0] memStoreData;
  logic [4:0]  memWriteIndex;
  logic        memMemRead;
  logic        memMemWrite;
  logic        memMemToReg;
  logic        memRegWrite;

  logic [4:0]  wbWriteIndex;
  logic [31:0] wbWriteData;
  logic        wbRegWrite;

  // ****************************************
  // Pipeline stages
  // ****************************************
  FetchStage #(.instrMemWords(instrMemWords)) fetchStage (
    .clk, .reset, .run, .stall,
    .imemWrite, .imemAddress, .imemData,
    .idInstruction, .idValid
  );

  DecodeStage decodeStage (
    .clk, .reset, .idInstruction, .idValid,
    .wbWriteIndex, .wbWriteData, .wbRegWrite,
    .stall,
    .exLhsValue, .exRhsValue, .exLhsIndex, .exRhsIndex, .exWriteIndex,
    .exImmediate, .exAluOp, .exAluSrc,
    .exMemRead, .exMemWrite, .exMemToReg, .exRegWrite
  );

  ExecuteStage executeStage (
    .clk, .reset,
    .exLhsValue, .exRhsValue, .exLhsIndex, .exRhsIndex, .exWriteIndex,
    .exImmediate, .exAluOp, .exAluSrc,
    .exMemRead, .exMemWrite, .exMemToReg, .exRegWrite,
    .wbWriteIndex, .wbWriteData, .wbRegWrite,
    .memAluResult, .memStoreData, .memWriteIndex,
    .memMemRead, .memMemWrite, .memMemToReg, .memRegWrite
  );

  MemoryStage #(.dataMemWords(dataMemWords)) memoryStage (
    .clk, .reset,
    .memAluResult, .memStoreData, .memWriteIndex,
    .memMemRead, .memMemWrite, .memMemToReg, .memRegWrite,
    .wbWriteIndex, .wbWriteData, .wbRegWrite
  );

  // Trace of every retired register write
  assign wbValid = wbRegWrite;
  assign wbIndex = wbWriteIndex;
  assign wbData  = wbWriteData;

endmodule

//--- sim/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Architectural state that lives across programs like the core's own state
logic [31:0] modelRegs [32] = '{default: 32'd0};
logic [31:0] modelMem [dataWords];

function automatic logic [31:0] regValue(input logic [4:0] index);
  if (index == 5'd0) begin
    return 32'd0;
  end
  return modelRegs[index];
endfunction

function automatic bit regOpOf(input logic [6:0] f7, input logic [2:0] f3, output aluOp_t op);
  op = aluAdd;
  if (f7 == funct7Sub) begin
    op = aluSub;
    return f3 == funct3AddSub;
  end
  if (f7 != funct7Base) begin
    return 1'b0;
  end
  case (f3)
    funct3AddSub: op = aluAdd;
    funct3Sll:    op = aluSll;
    funct3Slt:    op = aluSlt;
    funct3Xor:    op = aluXor;
    funct3Srl:    op = aluSrl;
    funct3Or:     op = aluOr;
    funct3And:    op = aluAnd;
    default:      return 1'b0;
  endcase
  return 1'b1;
endfunction

// No shift immediates in the subset
function automatic bit immOpOf(input logic [2:0] f3, output aluOp_t op);
  op = aluAdd;
  case (f3)
    funct3AddSub: op = aluAdd;
    funct3Slt:    op = aluSlt;
    funct3Xor:    op = aluXor;
    funct3Or:     op = aluOr;
    funct3And:    op = aluAnd;
    default:      return 1'b0;
  endcase
  return 1'b1;
endfunction

function automatic logic [31:0] aluModel(input aluOp_t op, input logic [31:0] a,
                                         input logic [31:0] b);
  case (op)
    aluAdd: return a + b;
    aluSub: return a - b;
    aluAnd: return a & b;
    aluOr:  return a | b;
    aluXor: return a ^ b;
    aluSlt: begin
      // Differing signs decide on their own
      if (a[31] != b[31]) begin
        return {31'd0, a[31]};
      end
      return {31'd0, a < b};
    end
    aluSll: return a << b[4:0];
    aluSrl: return a >> b[4:0];
    default: return 32'd0;
  endcase
endfunction

// Runs the loaded program one instruction at a time, queueing every register write
function automatic void runModel();
  rvInstr_t            instr;
  aluOp_t              op;
  logic [31:0]         lhs;
  logic [31:0]         rhs;
  logic [31:0]         result;
  logic [31:0]         address;
  logic [wordBits-1:0] word;
  bit                  writes;
  int                  i;
  for (i = 0; i < programWords.size(); i++) begin
    instr  = programWords[i];
    lhs    = regValue(instr.rType.rs1);
    rhs    = regValue(instr.rType.rs2);
    writes = 1'b0;
    result = 32'd0;
    case (instr.rType.opcode)
      opReg: begin
        writes = regOpOf(instr.rType.funct7, instr.rType.funct3, op);
        if (writes) begin
          result = aluModel(op, lhs, rhs);
        end
      end
      opImm: begin
        writes = immOpOf(instr.iType.funct3, op);
        if (writes) begin
          result = aluModel(op, lhs, {{20{instr.iType.imm12[11]}}, instr.iType.imm12});
        end
      end
      opLoad: begin
        if (instr.iType.funct3 == funct3Word) begin
          address = lhs + {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
          word    = address[wordBits+1:2];
          result  = modelMem[word];
          writes  = 1'b1;
        end
      end
      opStore: begin
        if (instr.sType.funct3 == funct3Word) begin
          address = lhs + {{20{instr.sType.immHigh[6]}}, instr.sType.immHigh,
                           instr.sType.immLow};
          word    = address[wordBits+1:2];
          modelMem[word] = rhs;
        end
      end
      default: writes = 1'b0;
    endcase
    if (writes && instr.rType.rd != 5'd0) begin
      modelRegs[instr.rType.rd] = result;
      expIndex.push_back(instr.rType.rd);
      expData.push_back(result);
    end
  end
endfunction

`endif

//--- sim/CpuTb.sv
`timescale 1ns/100ps

module CpuTb
  import rvIsaPkg::*;
();

  localparam int instrWords  = 128;
  localparam int dataWords   = 32;
  localparam int wordBits    = $clog2(dataWords);
  localparam int drainCycles = 5;
  // Every program ends with a write to this register
  localparam logic [4:0] markerReg = 5'd31;

  localparam logic [2:0] regFunct3 [8] = '{funct3AddSub, funct3AddSub, funct3Sll, funct3Slt,
                                           funct3Xor, funct3Srl, funct3Or, funct3And};
  localparam logic [2:0] immFunct3 [5] = '{funct3AddSub, funct3Slt, funct3Xor, funct3Or,
                                           funct3And};

  logic        clk;
  logic        reset;
  logic        run;
  logic        imemWrite;
  logic [31:0] imemAddress;
  logic [31:0] imemData;
  logic        wbValid;
  logic [4:0]  wbIndex;
  logic [31:0] wbData;

  logic [31:0] programWords [$];
  logic [4:0]  expIndex [$];
  logic [31:0] expData [$];
  bit          memWritten [dataWords];
  string       testName = "reset";
  int          testCount = 0;
  int          markerCount = 0;
  int          instrTotal = 0;
  int          runCycles = 0;
  integer      seed;

  `include "cpuModel.svh"

  Cpu #(
    .instrMemWords(instrWords),
    .dataMemWords(dataWords)
  ) uut (
    .clk, .reset, .run,
    .imemWrite, .imemAddress, .imemData,
    .wbValid, .wbIndex, .wbData
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ****************************************
  // Checking
  // ****************************************
  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      failRun($sformatf("FAILED %s: expected %h, actual %h", what, expected, actual));
    end
  endtask

  // Trace outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin : compareWrites
    logic [4:0]  wantIndex;
    logic [31:0] wantData;
    if (!reset && wbValid) begin
      if (expIndex.size() == 0) begin
        failRun($sformatf("%s: register write to x%0d that the model never made",
                          testName, wbIndex));
      end else begin
        wantIndex = expIndex.pop_front();
        wantData  = expData.pop_front();
        checkValue({testName, " index"}, {27'd0, wantIndex}, {27'd0, wbIndex});
        checkValue({testName, " data"}, wantData, wbData);
        if (wbIndex == markerReg) begin
          markerCount++;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (run) begin
      runCycles++;
      if (runCycles > 2 * instrTotal + 200) begin
        failRun($sformatf("%s: timed out after %0d running cycles", testName, runCycles));
      end
    end
  end

  // ****************************************
  // Program assembly
  // ****************************************
  function automatic int randBelow(input int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    rvInstr_t word;
    word.rType.funct7 = f7;
    word.rType.rs2    = rs2;
    word.rType.rs1    = rs1;
    word.rType.funct3 = f3;
    word.rType.rd     = rd;
    word.rType.opcode = opReg;
    return word;
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [6:0] opcode, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    rvInstr_t word;
    word.iType.imm12  = imm;
    word.iType.rs1    = rs1;
    word.iType.funct3 = f3;
    word.iType.rd     = rd;
    word.iType.opcode = opcode;
    return word;
  endfunction

  function automatic logic [31:0] sTypeWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    rvInstr_t word;
    word.sType.immHigh = imm[11:5];
    word.sType.rs2     = rs2;
    word.sType.rs1     = rs1;
    word.sType.funct3  = funct3Word;
    word.sType.immLow  = imm[4:0];
    word.sType.opcode  = opStore;
    return word;
  endfunction

  task automatic regOp(input logic [6:0] f7, input logic [2:0] f3, input int rd,
                       input int rs1, input int rs2);
    programWords.push_back(rTypeWord(f7, f3, 5'(rd), 5'(rs1), 5'(rs2)));
  endtask

  task automatic immOp(input logic [2:0] f3, input int rd, input int rs1, input int imm);
    programWords.push_back(iTypeWord(opImm, f3, 5'(rd), 5'(rs1), 12'(imm)));
  endtask

  // Loads and stores address data words from x0
  task automatic loadWord(input int rd, input int word);
    programWords.push_back(iTypeWord(opLoad, funct3Word, 5'(rd), 5'd0, 12'(word * 4)));
  endtask

  task automatic storeWord(input int rs2, input int word);
    programWords.push_back(sTypeWord(5'(rs2), 5'd0, 12'(word * 4)));
    memWritten[wordBits'(word)] = 1'b1;
  endtask

  // ****************************************
  // Programs
  // ****************************************
  task automatic aluProgram();
    immOp(funct3AddSub, 1, 0, -7);
    immOp(funct3AddSub, 2, 0, 5);
    regOp(funct7Base, funct3Slt, 3, 1, 2);
    regOp(funct7Base, funct3Slt, 4, 2, 1);
    immOp(funct3Slt, 5, 1, -3);
    // 35 shifts by 3
    immOp(funct3AddSub, 6, 0, 35);
    regOp(funct7Base, funct3Sll, 7, 2, 6);
    regOp(funct7Base, funct3Srl, 8, 1, 6);
    regOp(funct7Sub, funct3AddSub, 9, 2, 1);
    regOp(funct7Base, funct3AddSub, 10, 1, 2);
    regOp(funct7Base, funct3And, 11, 1, 6);
    regOp(funct7Base, funct3Or, 12, 2, 6);
    regOp(funct7Base, funct3Xor, 13, 1, 2);
    immOp(funct3Xor, 14, 2, 'h0f0);
    immOp(funct3Or, 15, 1, 'h100);
    immOp(funct3And, 16, 1, 'h7f0);
  endtask

  task automatic forwardProgram();
    immOp(funct3AddSub, 10, 0, 100);
    regOp(funct7Base, funct3AddSub, 11, 10, 10);
    immOp(funct3AddSub, 12, 11, 1);
    regOp(funct7Sub, funct3AddSub, 13, 12, 11);
    regOp(funct7Base, funct3AddSub, 14, 11, 13);
    immOp(funct3AddSub, 15, 0, 7);
    immOp(funct3AddSub, 16, 0, 1);
    regOp(funct7Base, funct3Sll, 17, 15, 16);
    regOp(funct7Base, funct3Or, 18, 17, 15);
  endtask

  task automatic storeLoadProgram();
    immOp(funct3AddSub, 1, 0, 'h55);
    storeWord(1, 2);
    loadWord(2, 2);
    immOp(funct3AddSub, 3, 0, -1);
    storeWord(3, 3);
    loadWord(4, 3);
    immOp(funct3AddSub, 5, 0, 77);
    immOp(funct3AddSub, 6, 0, 1);
    storeWord(5, 4);
    loadWord(7, 4);
    storeWord(6, 2);
    loadWord(8, 2);
  endtask

  task automatic loadUseProgram();
    immOp(funct3AddSub, 1, 0, 300);
    storeWord(1, 5);
    loadWord(2, 5);
    regOp(funct7Base, funct3AddSub, 3, 2, 2);
    loadWord(4, 5);
    immOp(funct3AddSub, 5, 4, 1);
    loadWord(6, 5);
    regOp(funct7Sub, funct3AddSub, 7, 0, 6);
    loadWord(8, 5);
    storeWord(8, 6);
    loadWord(9, 6);
  endtask

  task automatic zeroRegProgram();
    immOp(funct3AddSub, 0, 0, 55);
    regOp(funct7Base, funct3AddSub, 0, 1, 1);
    loadWord(0, 5);
    regOp(funct7Base, funct3AddSub, 10, 0, 0);
    immOp(funct3Or, 11, 0, 0);
    regOp(funct7Base, funct3Or, 12, 0, 1);
    immOp(funct3AddSub, 13, 0, 3);
  endtask

  task automatic randomProgram();
    int                  kind;
    logic [2:0]          sel;
    logic [wordBits-1:0] probe;
    for (int r = 1; r < 8; r++) begin
      immOp(funct3AddSub, r, 0, randBelow(4096));
    end
    repeat (40) begin
      kind  = randBelow(10);
      probe = wordBits'(randBelow(dataWords));
      if (kind < 4) begin
        sel = 3'(randBelow(8));
        regOp(sel == 3'd1 ? funct7Sub : funct7Base, regFunct3[sel], randBelow(8),
              randBelow(8), randBelow(8));
      end else if (kind < 6) begin
        sel = 3'(randBelow(5));
        immOp(immFunct3[sel], randBelow(8), randBelow(8), randBelow(4096));
      end else if (kind < 8) begin
        // Only load words that hold a known value
        repeat (dataWords) begin
          if (!memWritten[probe]) begin
            probe = probe + 1'b1;
          end
        end
        if (memWritten[probe]) begin
          loadWord(randBelow(8), int'(probe));
        end else begin
          storeWord(randBelow(8), int'(probe));
        end
      end else begin
        storeWord(randBelow(8), int'(probe));
      end
    end
  endtask

  // ****************************************
  // Running a program
  // ****************************************
  task automatic loadProgram();
    for (int i = 0; i < instrWords; i++) begin
      @(negedge clk);
      imemWrite   = 1'b1;
      imemAddress = i;
      imemData    = (i < programWords.size()) ? programWords[i] : 32'd0;
    end
    @(negedge clk);
    imemWrite = 1'b0;
  endtask

  task automatic runProgram(input string name);
    testName = name;
    testCount++;
    immOp(funct3AddSub, int'(markerReg), 0, testCount);
    runModel();
    instrTotal += programWords.size();
    loadProgram();
    run = 1'b1;
    // Writes retire in order, so the marker comes last
    while (markerCount < testCount) begin
      @(posedge clk);
    end
    @(negedge clk);
    run = 1'b0;
    repeat (drainCycles) @(negedge clk);
    if (expIndex.size() != 0) begin
      failRun($sformatf("%s: %0d expected register writes never appeared",
                        testName, expIndex.size()));
    end
    programWords.delete();
  endtask

  initial begin
    seed        = 32'h4df8511a;
    reset       = 1'b1;
    run         = 1'b0;
    imemWrite   = 1'b0;
    imemAddress = 32'd0;
    imemData    = 32'd0;
    memWritten  = '{default: 1'b0};
    repeat (8) @(negedge clk);
    reset = 1'b0;

    aluProgram();
    runProgram("aluOps");
    forwardProgram();
    runProgram("forwarding");
    storeLoadProgram();
    runProgram("storeLoad");
    loadUseProgram();
    runProgram("loadUse");
    zeroRegProgram();
    runProgram("zeroReg");
    randomProgram();
    runProgram("random");

    $display("test passed");
    $finish;
  end

endmodule

//--- compile.f
rtl/rvIsaPkg.sv
rtl/pipeCtrlPkg.sv
rtl/FetchStage.sv
rtl/DecodeStage.sv
rtl/ExecuteStage.sv
rtl/MemoryStage.sv
rtl/Cpu.sv
+incdir+sim
sim/CpuTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := CpuTb
FILELIST  := compile.f
OBJDIR    := obj_dir

.PHONY: run build lint clean

run: build
	./$(OBJDIR)/V$(TOP)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
